// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;    // Data word, PC or address
    typedef logic [31:0] inst_t;    // Raw instruction word
    typedef logic [3:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    localparam word_t INST_SIZE = 32'd4;

    // Primary opcodes, instruction bits 31..26
    typedef enum logic [5:0] {
        OP1_ALUR = 6'b000000,
        OP1_BEQ  = 6'b001000,
        OP1_BLT  = 6'b001001,
        OP1_BLE  = 6'b001010,
        OP1_BNE  = 6'b001011,
        OP1_JAL  = 6'b001100,
        OP1_LW   = 6'b010010,
        OP1_SW   = 6'b011010,
        OP1_ADDI = 6'b100000,
        OP1_ANDI = 6'b100100,
        OP1_ORI  = 6'b100101,
        OP1_XORI = 6'b100110
    } op1_e;

    // ALU functions for ALUR, instruction bits 25..18
    typedef enum logic [7:0] {
        OP2_EQ   = 8'b00001000,
        OP2_LT   = 8'b00001001,
        OP2_LE   = 8'b00001010,
        OP2_NE   = 8'b00001011,
        OP2_ADD  = 8'b00100000,
        OP2_AND  = 8'b00100100,
        OP2_OR   = 8'b00100101,
        OP2_XOR  = 8'b00100110,
        OP2_SUB  = 8'b00101000,
        OP2_NAND = 8'b00101100,
        OP2_NOR  = 8'b00101101,
        OP2_NXOR = 8'b00101110,
        OP2_RSHF = 8'b00110000,
        OP2_LSHF = 8'b00110001
    } op2_e;

    typedef enum logic [1:0] {
        WB_PC  = 2'd0,  // Link address for JAL
        WB_MEM = 2'd1,
        WB_ALU = 2'd2
    } wb_src_e;

    typedef struct packed {
        inst_t inst;
        word_t pc_next;
    } fetch_t;

    typedef struct packed {
        op1_e     op1;
        op2_e     op2;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;      // Already sign-extended
        word_t    pc_next;
        reg_idx_t dst;
        logic     reg_we;
        logic     mem_we;
        logic     mem_re;
        wb_src_e  wb_src;
    } decoded_t;

    typedef struct packed {
        word_t    alu_out;  // Doubles as the memory address
        word_t    store_data;
        word_t    pc_next;
        reg_idx_t dst;
        logic     reg_we;
        logic     mem_we;
        logic     mem_re;
        wb_src_e  wb_src;
    } exec_t;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    value;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // An all-zero instruction decodes to ALUR with op2 zero and writes nothing
    localparam fetch_t FETCH_BUBBLE = '{inst: '0, pc_next: '0};

    localparam decoded_t DEC_BUBBLE = '{
        op1: OP1_ALUR, op2: op2_e'(8'h00), rs_val: '0, rt_val: '0, imm: '0,
        pc_next: '0, dst: '0, reg_we: 1'b0, mem_we: 1'b0, mem_re: 1'b0,
        wb_src: WB_ALU
    };

    localparam exec_t EXEC_BUBBLE = '{
        alu_out: '0, store_data: '0, pc_next: '0, dst: '0,
        reg_we: 1'b0, mem_we: 1'b0, mem_re: 1'b0, wb_src: WB_ALU
    };

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
    import cpu_pkg::*;
#(
    parameter word_t START_PC       = 32'h100,
    parameter int    IMEM_ADDR_BITS = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  logic      prog_we,
    input  word_t     prog_addr,    // Word index, not a byte address
    input  inst_t     prog_data,
    input  logic      stall,
    input  redirect_t redirect,
    output fetch_t    fetch
);

    localparam int IMEM_WORDS = 1 << (IMEM_ADDR_BITS - 2);

    inst_t imem [IMEM_WORDS];
    word_t pc;
    word_t pc_plus;
    inst_t inst_rd;

    assign pc_plus = pc + INST_SIZE;
    assign inst_rd = imem[pc[IMEM_ADDR_BITS-1:2]];  // Asynchronous read

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr[IMEM_ADDR_BITS-3:0]] <= prog_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= START_PC;
            fetch <= FETCH_BUBBLE;
        end else if (redirect.valid) begin
            pc    <= redirect.target;
            fetch <= FETCH_BUBBLE;  // Squash the wrong-path fetch
        end else if (stall) begin
            pc    <= pc;
            fetch <= fetch;
        end else if (!run) begin
            fetch <= FETCH_BUBBLE;  // PC holds while halted
        end else begin
            pc    <= pc_plus;
            fetch <= '{inst: inst_rd, pc_next: pc_plus};
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  fetch_t    fetch,
    input  redirect_t redirect,
    input  wb_t       wb,
    output logic      stall,
    output decoded_t  decoded
);

    op1_e     op1;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     imm;
    word_t    regs [16];
    logic     is_alur;
    logic     is_branch;
    logic     is_jal;
    logic     is_load;
    logic     is_store;
    logic     is_imm;
    logic     uses_rt;
    reg_idx_t dst;
    decoded_t dec_next;

    // Destination of the instruction now in the execute latch
    reg_idx_t ex_dst;
    logic     ex_we;

    assign op1 = op1_e'(fetch.inst[31:26]);
    assign imm = fetch.inst[23:8];
    assign rd  = fetch.inst[11:8];
    assign rs  = fetch.inst[7:4];
    assign rt  = fetch.inst[3:0];

    assign is_alur   = (op1 == OP1_ALUR);
    assign is_branch = (op1 == OP1_BEQ) || (op1 == OP1_BLT) ||
                       (op1 == OP1_BLE) || (op1 == OP1_BNE);
    assign is_jal    = (op1 == OP1_JAL);
    assign is_load   = (op1 == OP1_LW);
    assign is_store  = (op1 == OP1_SW);
    assign is_imm    = (op1 == OP1_ADDI) || (op1 == OP1_ANDI) ||
                       (op1 == OP1_ORI) || (op1 == OP1_XORI);

    assign uses_rt = is_alur || is_branch || is_store;
    assign dst     = is_alur ? rd : rt;

    // True when a younger read of src must wait for a pending write
    function automatic logic pending(reg_idx_t src);
        logic hit_dec;
        logic hit_ex;
        logic hit_mem;
        hit_dec = decoded.reg_we && (decoded.dst == src);
        hit_ex  = ex_we && (ex_dst == src);
        hit_mem = wb.we && (wb.idx == src);
        return (src != '0) && (hit_dec || hit_ex || hit_mem);
    endfunction

    always_comb stall = pending(rs) || (uses_rt && pending(rt));

    always_comb begin
        dec_next.op1     = op1;
        dec_next.op2     = op2_e'(fetch.inst[25:18]);
        dec_next.rs_val  = (rs == '0) ? '0 : regs[rs];     // r0 reads as zero
        dec_next.rt_val  = (rt == '0) ? '0 : regs[rt];
        dec_next.imm     = {{16{imm[15]}}, imm};
        dec_next.pc_next = fetch.pc_next;
        dec_next.dst     = dst;
        // Writes to r0 are dropped here, so r0 never looks busy
        dec_next.reg_we  = (is_alur || is_jal || is_load || is_imm) && (dst != '0);
        dec_next.mem_we  = is_store;
        dec_next.mem_re  = is_load;
        if (is_jal)
            dec_next.wb_src = WB_PC;
        else if (is_load)
            dec_next.wb_src = WB_MEM;
        else
            dec_next.wb_src = WB_ALU;
    end

    // Register file, written by the MEM latch on the rising edge
    always_ff @(posedge clk) begin
        if (wb.we && (wb.idx != '0))
            regs[wb.idx] <= wb.value;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            decoded <= DEC_BUBBLE;
            ex_dst  <= '0;
            ex_we   <= 1'b0;
        end else begin
            ex_dst <= decoded.dst;      // Execute latch always takes decode latch
            ex_we  <= decoded.reg_we;
            if (redirect.valid || stall)
                decoded <= DEC_BUBBLE;  // Flush, or bubble while fetch holds
            else
                decoded <= dec_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  decoded_t  decoded,
    output redirect_t redirect,
    output exec_t     executed
);

    word_t a;
    word_t b;
    word_t imm4;
    word_t alu_out;
    logic  taken;

    assign a    = decoded.rs_val;
    assign b    = decoded.rt_val;
    assign imm4 = decoded.imm << 2;     // Branch offsets count words

    always_comb begin
        case (decoded.op1)
            OP1_ALUR: begin
                case (decoded.op2)
                    OP2_EQ:   alu_out = {31'b0, a == b};
                    OP2_LT:   alu_out = {31'b0, $signed(a) < $signed(b)};
                    OP2_LE:   alu_out = {31'b0, $signed(a) <= $signed(b)};
                    OP2_NE:   alu_out = {31'b0, a != b};
                    OP2_ADD:  alu_out = a + b;
                    OP2_AND:  alu_out = a & b;
                    OP2_OR:   alu_out = a | b;
                    OP2_XOR:  alu_out = a ^ b;
                    OP2_SUB:  alu_out = a - b;
                    OP2_NAND: alu_out = ~(a & b);
                    OP2_NOR:  alu_out = ~(a | b);
                    OP2_NXOR: alu_out = ~(a ^ b);
                    OP2_RSHF: alu_out = $signed(a) >>> b;   // Arithmetic
                    OP2_LSHF: alu_out = a << b;
                    default:  alu_out = '0;                 // Bubbles land here
                endcase
            end
            OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + decoded.imm;
            OP1_ANDI: alu_out = a & decoded.imm;
            OP1_ORI:  alu_out = a | decoded.imm;
            OP1_XORI: alu_out = a ^ decoded.imm;
            default:  alu_out = '0;
        endcase
    end

    // Signed branch conditions
    always_comb begin
        case (decoded.op1)
            OP1_BEQ: taken = (a == b);
            OP1_BLT: taken = $signed(a) < $signed(b);
            OP1_BLE: taken = $signed(a) <= $signed(b);
            OP1_BNE: taken = (a != b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect.valid = taken || (decoded.op1 == OP1_JAL);
        if (decoded.op1 == OP1_JAL)
            redirect.target = a + imm4;     // Register-relative jump
        else
            redirect.target = decoded.pc_next + imm4;
    end

    // The branch itself always moves on, JAL still needs its link write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            executed <= EXEC_BUBBLE;
        end else begin
            executed.alu_out    <= alu_out;
            executed.store_data <= b;
            executed.pc_next    <= decoded.pc_next;
            executed.dst        <= decoded.dst;
            executed.reg_we     <= decoded.reg_we;
            executed.mem_we     <= decoded.mem_we;
            executed.mem_re     <= decoded.mem_re;
            executed.wb_src     <= decoded.wb_src;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage
    import cpu_pkg::*;
#(
    parameter int    DMEM_ADDR_BITS = 16,
    parameter word_t OUT_ADDR       = 32'hFFFFF020
) (
    input  logic  clk,
    input  logic  reset,
    input  exec_t executed,
    output wb_t   wb,
    output logic  out_valid,
    output word_t out_data
);

    localparam int DMEM_WORDS = 1 << (DMEM_ADDR_BITS - 2);

    word_t dmem [DMEM_WORDS];
    logic  is_out;
    word_t load_data;

    // Memory latch
    logic     mem_we_q;
    reg_idx_t mem_dst_q;
    wb_src_e  mem_src_q;
    word_t    mem_data_q;
    word_t    mem_alu_q;
    word_t    mem_link_q;

    assign is_out    = executed.mem_we && (executed.alu_out == OUT_ADDR);
    assign load_data = dmem[executed.alu_out[DMEM_ADDR_BITS-1:2]];

    // Output word is memory-mapped and never reaches the RAM
    always_ff @(posedge clk) begin
        if (executed.mem_we && !is_out)
            dmem[executed.alu_out[DMEM_ADDR_BITS-1:2]] <= executed.store_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_we_q  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            mem_we_q  <= executed.reg_we;
            out_valid <= is_out;    // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        mem_dst_q  <= executed.dst;
        mem_src_q  <= executed.wb_src;
        mem_alu_q  <= executed.alu_out;
        mem_link_q <= executed.pc_next;
        if (executed.mem_re)
            mem_data_q <= load_data;
        if (is_out)
            out_data <= executed.store_data;
    end

    assign wb.we  = mem_we_q;
    assign wb.idx = mem_dst_q;

    always_comb begin
        case (mem_src_q)
            WB_PC:   wb.value = mem_link_q;
            WB_MEM:  wb.value = mem_data_q;
            default: wb.value = mem_alu_q;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pipeline_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_cpu
    import cpu_pkg::*;
#(
    parameter word_t START_PC       = 32'h100,
    parameter int    IMEM_ADDR_BITS = 16,
    parameter int    DMEM_ADDR_BITS = 16,
    parameter word_t OUT_ADDR       = 32'hFFFFF020
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  run,
    input  logic  prog_we,
    input  word_t prog_addr,
    input  inst_t prog_data,
    output logic  out_valid,
    output word_t out_data
);

    fetch_t    fetch;
    decoded_t  decoded;
    exec_t     executed;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;

    fetch_unit #(
        .START_PC       (START_PC),
        .IMEM_ADDR_BITS (IMEM_ADDR_BITS)
    ) fetch_unit_i (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .stall     (stall),
        .redirect  (redirect),
        .fetch     (fetch)
    );

    decode_stage decode_stage_i (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetch),
        .redirect (redirect),
        .wb       (wb),
        .stall    (stall),
        .decoded  (decoded)
    );

    execute_stage execute_stage_i (
        .clk      (clk),
        .reset    (reset),
        .decoded  (decoded),
        .redirect (redirect),
        .executed (executed)
    );

    result_stage #(
        .DMEM_ADDR_BITS (DMEM_ADDR_BITS),
        .OUT_ADDR       (OUT_ADDR)
    ) result_stage_i (
        .clk       (clk),
        .reset     (reset),
        .executed  (executed),
        .wb        (wb),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: verification/cpu_tb_prog.svh
`ifndef CPU_TB_PROG_SVH
`define CPU_TB_PROG_SVH

// Program builder and reference model, included inside cpu_tb
// Uses prog, expect_q, START_PC, OUT_ADDR and the DUT input signals

// Register-register layout
function automatic inst_t alur_word(op2_e f, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {OP1_ALUR, f, 6'b0, rd, rs, rt};
endfunction

// Immediate, branch, jump, load and store layout
function automatic inst_t itype_word(op1_e op, imm_t imm, reg_idx_t rs, reg_idx_t rt);
    return {op, 2'b00, imm, rs, rt};
endfunction

function automatic void new_program();
    prog.delete();
    expect_q.delete();
endfunction

function automatic void emit(inst_t inst);
    prog.push_back(inst);
endfunction

// SW r to the output word, r0 plus the low half of OUT_ADDR
function automatic void emit_output(reg_idx_t r);
    emit(itype_word(OP1_SW, OUT_ADDR[15:0], 4'd0, r));
endfunction

function automatic word_t sign_extend(imm_t v);
    return {{16{v[15]}}, v};
endfunction

// Expected ALUR result, compares on signed values
function automatic word_t alu_model(op2_e f, word_t a, word_t b);
    case (f)
        OP2_EQ:   return word_t'(a == b);
        OP2_LT:   return word_t'($signed(a) < $signed(b));
        OP2_LE:   return word_t'($signed(a) <= $signed(b));
        OP2_NE:   return word_t'(a != b);
        OP2_ADD:  return a + b;
        OP2_AND:  return a & b;
        OP2_OR:   return a | b;
        OP2_XOR:  return a ^ b;
        OP2_SUB:  return a - b;
        OP2_NAND: return ~(a & b);
        OP2_NOR:  return ~(a | b);
        OP2_NXOR: return ~(a ^ b);
        OP2_RSHF: return $signed(a) >>> b[4:0];     // Counts stay below 32
        OP2_LSHF: return a << b[4:0];
        default:  return '0;
    endcase
endfunction

function automatic word_t imm_model(op1_e op, word_t a, imm_t imm);
    case (op)
        OP1_ANDI: return a & sign_extend(imm);
        OP1_ORI:  return a | sign_extend(imm);
        OP1_XORI: return a ^ sign_extend(imm);
        default:  return a + sign_extend(imm);
    endcase
endfunction

// One prog_we strobe per word, starting at the reset PC
task automatic load_program();
    int i;
    for (i = 0; i < prog.size(); i++) begin
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= (START_PC >> 2) + word_t'(i);
        prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
endtask

`endif

// File: verification/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
();

    localparam word_t START_PC = 32'h100;
    localparam word_t OUT_ADDR = 32'hFFFFF020;

    logic  clk;
    logic  reset;
    logic  run;
    logic  prog_we;
    word_t prog_addr;
    inst_t prog_data;
    logic  out_valid;
    word_t out_data;

    inst_t prog[$];             // Program being built
    word_t expect_q[$];         // Predicted output words
    word_t outs[$];             // Words seen on the output strobe
    int    cycles = 0;
    int    cycle_limit = 200;   // Grows with every program
    int    seed;

    `include "cpu_tb_prog.svh"

    pipeline_cpu #(
        .START_PC       (START_PC),
        .IMEM_ADDR_BITS (16),
        .DMEM_ADDR_BITS (16),
        .OUT_ADDR       (OUT_ADDR)
    ) pipeline_cpu_i (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Strobe is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (out_valid)
            outs.push_back(out_data);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "simulation did not finish in time");
        end
    end

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "output word mismatch");
        end
    endtask

    task automatic compare_count(string name, int expected, int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d strobes, actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "output strobe count mismatch");
        end
    endtask

    task automatic apply_reset();
        reset   <= 1'b1;
        run     <= 1'b0;
        prog_we <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        outs.delete();
    endtask

    task automatic run_program(string name);
        int k;
        emit(itype_word(OP1_BEQ, 16'hFFFF, 4'd0, 4'd0));    // Spin in place
        cycle_limit += prog.size() * 8;
        emit('0);   // Wrong-path fetch past the end reads these
        emit('0);
        apply_reset();
        load_program();
        run <= 1'b1;
        while (outs.size() < expect_q.size())
            @(posedge clk);
        repeat (20) @(posedge clk);     // Window for stray strobes
        compare_count(name, expect_q.size(), outs.size());
        for (k = 0; k < expect_q.size(); k++)
            compare_word(name, expect_q[k], outs[k]);
        run <= 1'b0;
    endtask

    task automatic idle_check();
        new_program();
        emit(itype_word(OP1_ADDI, 16'h0001, 4'd0, 4'd1));
        emit_output(4'd1);      // Would strobe if the core ran
        emit(itype_word(OP1_BEQ, 16'hFFFF, 4'd0, 4'd0));
        cycle_limit += prog.size() * 8;
        apply_reset();
        load_program();
        repeat (20) @(posedge clk);
        compare_count("idle", 0, outs.size());
    endtask

    task automatic alur_functions();
        op2_e f;
        imm_t a16;
        imm_t b16;
        new_program();
        f = OP2_EQ;
        repeat (14) begin
            a16 = imm_t'($urandom);
            b16 = imm_t'($urandom);
            if (f == OP2_RSHF || f == OP2_LSHF)
                b16 = imm_t'($urandom % 32);
            if (f == OP2_EQ)
                b16 = a16;  // Make the equal case true once
            emit(itype_word(OP1_ADDI, a16, 4'd0, 4'd1));
            emit(itype_word(OP1_ORI, b16, 4'd0, 4'd2));
            emit(alur_word(f, 4'd3, 4'd1, 4'd2));
            emit_output(4'd3);
            expect_q.push_back(alu_model(f, sign_extend(a16), sign_extend(b16)));
            f = f.next();
        end
        run_program("alur");
    endtask

    task automatic immediate_ops();
        op1_e ops[4];
        imm_t a16;
        imm_t n16;
        int   k;
        ops = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
        new_program();
        a16 = imm_t'($urandom);
        emit(itype_word(OP1_ADDI, a16, 4'd0, 4'd1));
        for (k = 0; k < 4; k++) begin
            n16 = imm_t'($urandom) | 16'h8000;     // Negative immediate
            emit(itype_word(ops[k], n16, 4'd1, reg_idx_t'(k + 2)));
            emit_output(reg_idx_t'(k + 2));
            expect_q.push_back(imm_model(ops[k], sign_extend(a16), n16));
        end
        run_program("immediates");
    endtask

    task automatic dependent_chain();
        imm_t x16;
        imm_t y16;
        new_program();
        x16 = imm_t'($urandom);
        y16 = imm_t'($urandom);
        emit(itype_word(OP1_ADDI, x16, 4'd0, 4'd1));
        emit(itype_word(OP1_ADDI, y16, 4'd0, 4'd2));
        repeat (5)
            emit(alur_word(OP2_ADD, 4'd1, 4'd1, 4'd2));    // Each reads the last
        emit_output(4'd1);
        expect_q.push_back(sign_extend(x16) + sign_extend(y16) * 32'd5);
        run_program("dependent chain");
    endtask

    // Offsets count words from the instruction after the branch
    task automatic countdown_loop();
        int n;
        int v;
        new_program();
        n = 3 + int'($urandom % 4);
        emit(itype_word(OP1_ADDI, imm_t'(n), 4'd0, 4'd1));     // Counter in r1
        emit(itype_word(OP1_ADDI, 16'h7BAD, 4'd0, 4'd5));      // Marker in r5
        emit_output(4'd1);                                    // Loop top
        emit(itype_word(OP1_ADDI, 16'hFFFF, 4'd1, 4'd1));
        emit(itype_word(OP1_BLE, 16'd2, 4'd1, 4'd0));          // Exit when r1 <= 0
        emit(itype_word(OP1_BLT, 16'hFFFC, 4'd0, 4'd1));       // Back to loop top
        emit_output(4'd5);
        emit(itype_word(OP1_BEQ, 16'd1, 4'd1, 4'd0));
        emit_output(4'd5);
        emit(itype_word(OP1_BNE, 16'd1, 4'd1, 4'd5));
        emit_output(4'd5);
        for (v = n; v > 0; v--)
            expect_q.push_back(word_t'(v));
        run_program("countdown");
    endtask

    task automatic store_load_jal();
        imm_t  d16;
        word_t link;
        new_program();
        d16 = imm_t'($urandom);
        emit(itype_word(OP1_ADDI, d16, 4'd0, 4'd1));
        emit(itype_word(OP1_ADDI, 16'h0200, 4'd0, 4'd2));      // Data base address
        emit(itype_word(OP1_SW, 16'd8, 4'd2, 4'd1));
        emit(itype_word(OP1_LW, 16'd8, 4'd2, 4'd3));
        emit_output(4'd3);
        expect_q.push_back(sign_extend(d16));
        link = START_PC + INST_SIZE * word_t'(prog.size()) + INST_SIZE;
        // Absolute target from r0, one word past the fall-through
        emit(itype_word(OP1_JAL, imm_t'((link >> 2) + 1), 4'd0, 4'd4));
        emit_output(4'd1);
        emit_output(4'd4);
        expect_q.push_back(link);
        run_program("store load jal");
    endtask

    initial begin
        reset     <= 1'b1;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        seed = $urandom(30774);
        idle_check();
        alur_functions();
        immediate_ops();
        dependent_chain();
        countdown_loop();
        store_load_jal();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: pipeline_cpu.f
+incdir+verification
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipeline_cpu.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module cpu_tb \
    -f pipeline_cpu.f -o cpu_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
